// ==== source/btb_pkg.sv ====
package btb_pkg;

    // instruction pointer geometry
    localparam int EIP_WIDTH   = 32;
    localparam int INDEX_WIDTH = 6;                        // eip[5:0] picks the entry
    localparam int TAG_WIDTH   = EIP_WIDTH - INDEX_WIDTH;  // eip[31:6]

    // direct mapped, so one entry per index value
    localparam int BTB_ENTRIES = 1 << INDEX_WIDTH;

    // fetch lines are 16 bytes wide
    localparam int FIP_OFFSET_BITS = 4;
    localparam int FIP_LINE_WIDTH  = EIP_WIDTH - FIP_OFFSET_BITS;

    // eip, branch target and the stored fetch addresses
    typedef logic [EIP_WIDTH-1:0] eip_t;

    // entry index taken from the low eip bits
    typedef logic [INDEX_WIDTH-1:0] index_t;

    // tag kept in each entry
    typedef logic [TAG_WIDTH-1:0] tag_t;

    // fetch line address handed back to fetch
    typedef logic [FIP_LINE_WIDTH-1:0] fip_line_t;

    // one bit per entry, used for load enables and match bits
    typedef logic [BTB_ENTRIES-1:0] entry_mask_t;

endpackage

// ==== source/btb_update_decode.sv ====
`timescale 1ns/1ps

// write side address decode
// the retiring branch eip is cut into an index and a tag. the index turns
// into a one-hot load vector, gated by the write-back valid strobe, so no
// more than one entry is written in any cycle

module btb_update_decode import btb_pkg::*; (
    input  logic        update_valid,  // branch retiring this cycle
    input  eip_t        eip_wb,        // eip of the branch instruction
    output entry_mask_t load,          // per entry load enable
    output tag_t        tag_write      // tag broadcast to every entry
);

    index_t index_write;

    // low bits select the line
    assign index_write = eip_wb[INDEX_WIDTH-1:0];

    // remaining upper bits form the tag
    assign tag_write = eip_wb[EIP_WIDTH-1:INDEX_WIDTH];

    // index to one-hot, each bit qualified by the strobe
    always_comb begin
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            load[i] = update_valid && (index_write == index_t'(i));
        end
    end

endmodule

// ==== source/btb_entry.sv ====
`timescale 1ns/1ps

// a single buffer line
// holds the valid bit, the tag, the predicted target and both fetch
// addresses of the branch, and compares its own tag against the lookup tag

module btb_entry import btb_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic load,          // write this entry at the next edge
    input  tag_t tag_write,
    input  eip_t target_write,
    input  eip_t fip_e_write,   // even fetch line address, full width
    input  eip_t fip_o_write,   // odd fetch line address, full width
    input  tag_t tag_lookup,    // broadcast from the fetch eip
    output logic match,
    output eip_t target,
    output eip_t fip_e,
    output eip_t fip_o
);

    logic valid;
    tag_t tag;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid  <= 1'b0;
            tag    <= '0;
            target <= '0;
            fip_e  <= '0;
            fip_o  <= '0;
        end else if (load) begin
            valid  <= 1'b1;          // stays set until the next reset
            tag    <= tag_write;
            target <= target_write;
            fip_e  <= fip_e_write;
            fip_o  <= fip_o_write;
        end
    end

    // a hit on this line needs a written entry and the same tag
    assign match = valid && (tag == tag_lookup);

endmodule

// ==== source/btb_lookup_select.sv ====
`timescale 1ns/1ps

// read side of the buffer
// the fetch index is decoded to one-hot and used to pick the match bit and
// the contents of that single entry. only the indexed entry can produce a
// hit, the match bits of all other entries are ignored. the stored fetch
// addresses are cut down to line addresses on the way out

module btb_lookup_select import btb_pkg::*; (
    input  index_t                  index_lookup,  // eip_fetch[5:0]
    input  entry_mask_t             match_all,
    input  eip_t [BTB_ENTRIES-1:0]  target_all,
    input  eip_t [BTB_ENTRIES-1:0]  fip_e_all,
    input  eip_t [BTB_ENTRIES-1:0]  fip_o_all,
    output logic                    hit,
    output logic                    miss,
    output eip_t                    eip_target,
    output fip_line_t               fip_e_target,
    output fip_line_t               fip_o_target
);

    entry_mask_t index_onehot;
    logic        hit_sel;
    eip_t        target_sel;
    eip_t        fip_e_sel;
    eip_t        fip_o_sel;

    // exactly one bit set for any index
    assign index_onehot = entry_mask_t'(1) << index_lookup;

    // only the addressed entry may hit
    assign hit_sel = |(match_all & index_onehot);

    // and-or mux over all entries, the one-hot keeps it to a single source
    always_comb begin
        target_sel = '0;
        fip_e_sel  = '0;
        fip_o_sel  = '0;
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            target_sel |= target_all[i] & {EIP_WIDTH{index_onehot[i]}};
            fip_e_sel  |= fip_e_all[i]  & {EIP_WIDTH{index_onehot[i]}};
            fip_o_sel  |= fip_o_all[i]  & {EIP_WIDTH{index_onehot[i]}};
        end
    end

    assign hit  = hit_sel;
    assign miss = ~hit_sel;

    // target is passed on even on a miss, fetch qualifies it with hit
    assign eip_target = target_sel;

    // drop the byte offset inside the fetch line
    assign fip_e_target = fip_e_sel[EIP_WIDTH-1:FIP_OFFSET_BITS];
    assign fip_o_target = fip_o_sel[EIP_WIDTH-1:FIP_OFFSET_BITS];

endmodule

// ==== source/btb_top.sv ====
`timescale 1ns/1ps

// direct mapped branch target buffer
// lookup from fetch is purely combinational, updates from write-back land
// at the rising edge in which update_valid is seen

module btb_top import btb_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      update_valid,  // one cycle strobe from the wb latch
    input  eip_t      eip_fetch,
    input  eip_t      eip_wb,
    input  eip_t      target_wb,
    input  eip_t      fip_e_wb,
    input  eip_t      fip_o_wb,
    output logic      hit,
    output logic      miss,
    output eip_t      eip_target,
    output fip_line_t fip_e_target,
    output fip_line_t fip_o_target
);

    index_t                 index_lookup;
    tag_t                   tag_lookup;
    entry_mask_t            load;
    tag_t                   tag_write;
    entry_mask_t            match_all;
    eip_t [BTB_ENTRIES-1:0] target_all;
    eip_t [BTB_ENTRIES-1:0] fip_e_all;
    eip_t [BTB_ENTRIES-1:0] fip_o_all;

    assign index_lookup = eip_fetch[INDEX_WIDTH-1:0];
    assign tag_lookup   = eip_fetch[EIP_WIDTH-1:INDEX_WIDTH];  // sent to every entry

    btb_update_decode u_update_decode (
        .update_valid (update_valid),
        .eip_wb       (eip_wb),
        .load         (load),
        .tag_write    (tag_write)
    );

    // write data goes straight from the ports to all lines
    for (genvar i = 0; i < BTB_ENTRIES; i++) begin : g_entry
        btb_entry u_entry (
            .clk          (clk),
            .reset        (reset),
            .load         (load[i]),
            .tag_write    (tag_write),
            .target_write (target_wb),
            .fip_e_write  (fip_e_wb),
            .fip_o_write  (fip_o_wb),
            .tag_lookup   (tag_lookup),
            .match        (match_all[i]),
            .target       (target_all[i]),
            .fip_e        (fip_e_all[i]),
            .fip_o        (fip_o_all[i])
        );
    end

    btb_lookup_select u_lookup_select (
        .index_lookup (index_lookup),
        .match_all    (match_all),
        .target_all   (target_all),
        .fip_e_all    (fip_e_all),
        .fip_o_all    (fip_o_all),
        .hit          (hit),
        .miss         (miss),
        .eip_target   (eip_target),
        .fip_e_target (fip_e_target),
        .fip_o_target (fip_o_target)
    );

endmodule

// ==== verification/btb_asserts.sv ====
`timescale 1ns/1ps

// output consistency checks on the buffer top level

module btb_asserts import btb_pkg::*; (
    input logic      clk,
    input logic      reset,
    input logic      hit,
    input logic      miss,
    input eip_t      eip_target,
    input fip_line_t fip_e_target,
    input fip_line_t fip_o_target
);

    // fetch reads only one of them, they must never disagree
    hit_miss_complement: assert property (
        @(posedge clk) disable iff (reset) hit == ~miss
    ) else $error("hit and miss are not complementary");

    // every entry is cleared, so nothing can hit right after reset
    no_hit_after_reset: assert property (
        @(posedge clk) reset |=> !hit
    ) else $error("hit set in the cycle after reset");

    outputs_known: assert property (
        @(posedge clk) disable iff (reset)
            !$isunknown({hit, miss, eip_target, fip_e_target, fip_o_target})
    ) else $error("lookup outputs unknown outside reset");

endmodule

// ==== verification/btb_tb.sv ====
`timescale 1ns/1ps

module btb_tb import btb_pkg::*; ();

    logic      clk = 1'b0;
    logic      reset;
    logic      update_valid;
    eip_t      eip_fetch;
    eip_t      eip_wb;
    eip_t      target_wb;
    eip_t      fip_e_wb;
    eip_t      fip_o_wb;
    logic      hit;
    logic      miss;
    eip_t      eip_target;
    fip_line_t fip_e_target;
    fip_line_t fip_o_target;

    // reference copy of the buffer contents
    logic model_valid [BTB_ENTRIES];
    tag_t model_tag [BTB_ENTRIES];
    eip_t model_target [BTB_ENTRIES];
    eip_t model_fip_e [BTB_ENTRIES];
    eip_t model_fip_o [BTB_ENTRIES];

    integer seed = 32'hd1b4ff74;
    int     error_count = 0;
    int     cycles_checked = 0;
    eip_t   pool [8];              // small set of eips so random lookups can hit

    always #2 clk = ~clk;

    btb_top u_dut (
        .clk          (clk),
        .reset        (reset),
        .update_valid (update_valid),
        .eip_fetch    (eip_fetch),
        .eip_wb       (eip_wb),
        .target_wb    (target_wb),
        .fip_e_wb     (fip_e_wb),
        .fip_o_wb     (fip_o_wb),
        .hit          (hit),
        .miss         (miss),
        .eip_target   (eip_target),
        .fip_e_target (fip_e_target),
        .fip_o_target (fip_o_target)
    );

    bind btb_top btb_asserts u_asserts (
        .clk          (clk),
        .reset        (reset),
        .hit          (hit),
        .miss         (miss),
        .eip_target   (eip_target),
        .fip_e_target (fip_e_target),
        .fip_o_target (fip_o_target)
    );

    // data is taken from the indexed entry even on a miss
    function automatic logic expected_lookup(input eip_t eip, output eip_t target,
                                             output fip_line_t fip_e_line,
                                             output fip_line_t fip_o_line);
        index_t idx;
        idx        = eip[INDEX_WIDTH-1:0];
        target     = model_target[idx];
        fip_e_line = model_fip_e[idx][EIP_WIDTH-1:FIP_OFFSET_BITS];
        fip_o_line = model_fip_o[idx][EIP_WIDTH-1:FIP_OFFSET_BITS];
        return model_valid[idx] && (model_tag[idx] == eip[EIP_WIDTH-1:INDEX_WIDTH]);
    endfunction

    // outputs are read before the edge takes effect, then the model follows the write
    always @(posedge clk) begin
        logic      exp_hit;
        eip_t      exp_target;
        fip_line_t exp_fip_e;
        fip_line_t exp_fip_o;
        index_t    widx;
        if (reset) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                model_valid[i]  = 1'b0;
                model_tag[i]    = '0;
                model_target[i] = '0;
                model_fip_e[i]  = '0;
                model_fip_o[i]  = '0;
            end
        end else begin
            exp_hit = expected_lookup(eip_fetch, exp_target, exp_fip_e, exp_fip_o);
            if (hit !== exp_hit) begin
                error_count++;
                $display("FAIL hit expected %h got %h", exp_hit, hit);
            end
            if (miss !== ~exp_hit) begin
                error_count++;
                $display("FAIL miss expected %h got %h", ~exp_hit, miss);
            end
            if (eip_target !== exp_target) begin
                error_count++;
                $display("FAIL eip_target expected %h got %h", exp_target, eip_target);
            end
            if (fip_e_target !== exp_fip_e) begin
                error_count++;
                $display("FAIL fip_e_target expected %h got %h", exp_fip_e, fip_e_target);
            end
            if (fip_o_target !== exp_fip_o) begin
                error_count++;
                $display("FAIL fip_o_target expected %h got %h", exp_fip_o, fip_o_target);
            end
            cycles_checked++;
            if (update_valid) begin
                widx               = eip_wb[INDEX_WIDTH-1:0];
                model_valid[widx]  = 1'b1;
                model_tag[widx]    = eip_wb[EIP_WIDTH-1:INDEX_WIDTH];
                model_target[widx] = target_wb;
                model_fip_e[widx]  = fip_e_wb;
                model_fip_o[widx]  = fip_o_wb;
            end
        end
    end

    task automatic report_timeout(input string what);
        error_count++;
        $display("timeout while waiting for %s", what);
    endtask

    // one cycle of stimulus applied at the falling edge
    task automatic drive_cycle(input eip_t fetch, input logic valid, input eip_t wb,
                               input eip_t target, input eip_t fip_e, input eip_t fip_o);
        @(negedge clk);
        eip_fetch    = fetch;
        update_valid = valid;
        eip_wb       = wb;
        target_wb    = target;
        fip_e_wb     = fip_e;
        fip_o_wb     = fip_o;
    endtask

    task automatic check_hit_now(input logic expected, input string what);
        #1;  // lookup path has settled by mid cycle
        if (hit !== expected) begin
            error_count++;
            $display("FAIL hit (%s) expected %h got %h", what, expected, hit);
        end
    endtask

    task automatic apply_reset();
        int waited;
        reset        = 1'b1;
        update_valid = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset  = 1'b0;
        waited = 0;
        while (miss !== 1'b1 && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (miss !== 1'b1) begin
            report_timeout("miss to rise after reset");
        end
    endtask

    // let the checker see the last driven cycles
    task automatic drain_checks();
        int target;
        int waited;
        target = cycles_checked + 2;
        waited = 0;
        while (cycles_checked < target && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (cycles_checked < target) begin
            report_timeout("the checker to catch up");
        end
    endtask

    initial begin
        eip_t        a;
        eip_t        b;
        eip_t        c;
        eip_t        fetch;
        eip_t        wb;
        logic [31:0] r;
        eip_fetch = '0;
        eip_wb    = '0;
        target_wb = '0;
        fip_e_wb  = '0;
        fip_o_wb  = '0;
        apply_reset();

        // empty buffer misses everywhere
        repeat (8) begin
            drive_cycle($random(seed), 1'b0, '0, '0, '0, '0);
            check_hit_now(1'b0, "after reset");
        end

        // write then read back
        a = $random(seed);
        drive_cycle('0, 1'b1, a, $random(seed), $random(seed), $random(seed));
        drive_cycle(a, 1'b0, '0, '0, '0, '0);
        check_hit_now(1'b1, "written eip");

        // same index, other tag
        b = {~a[EIP_WIDTH-1:INDEX_WIDTH], a[INDEX_WIDTH-1:0]};
        drive_cycle(b, 1'b0, '0, '0, '0, '0);
        check_hit_now(1'b0, "tag mismatch");
        drive_cycle('0, 1'b1, b, $random(seed), $random(seed), $random(seed));
        drive_cycle(a, 1'b0, '0, '0, '0, '0);
        check_hit_now(1'b0, "replaced eip");
        drive_cycle(b, 1'b0, '0, '0, '0, '0);
        check_hit_now(1'b1, "replacing eip");

        // lookup during a write to the same index sees the old entry
        c = {a[EIP_WIDTH-1:INDEX_WIDTH] + 26'd1, a[INDEX_WIDTH-1:0]};
        drive_cycle(b, 1'b1, c, $random(seed), $random(seed), $random(seed));
        check_hit_now(1'b1, "old contents during write");
        drive_cycle(b, 1'b0, '0, '0, '0, '0);
        check_hit_now(1'b0, "old eip after write");
        drive_cycle(c, 1'b0, '0, '0, '0, '0);
        check_hit_now(1'b1, "new eip after write");

        // random traffic checked every cycle by the compare process
        for (int k = 0; k < 8; k++) begin
            pool[k] = $random(seed);
        end
        for (int n = 0; n < 400; n++) begin
            r     = $random(seed);
            fetch = r[0] ? pool[r[3:1]] : eip_t'($random(seed));
            wb    = r[4] ? pool[r[7:5]] : eip_t'($random(seed));
            drive_cycle(fetch, r[8], wb, $random(seed), $random(seed), $random(seed));
        end

        // reset in the middle of the run wipes every entry
        drive_cycle('0, 1'b1, c, $random(seed), $random(seed), $random(seed));
        drive_cycle(c, 1'b0, '0, '0, '0, '0);
        check_hit_now(1'b1, "directed eip before mid-run reset");
        @(negedge clk);
        apply_reset();
        for (int k = 0; k < 8; k++) begin
            drive_cycle(pool[k], 1'b0, '0, '0, '0, '0);
            check_hit_now(1'b0, "pool eip after mid-run reset");
        end
        drive_cycle(c, 1'b0, '0, '0, '0, '0);
        check_hit_now(1'b0, "directed eip after mid-run reset");

        drain_checks();
        $display("errors: %0d, cycles checked: %0d", error_count, cycles_checked);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== btb.f ====
source/btb_pkg.sv
source/btb_update_decode.sv
source/btb_entry.sv
source/btb_lookup_select.sv
source/btb_top.sv
verification/btb_asserts.sv
verification/btb_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the branch target buffer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module btb_tb -f btb.f -o Vbtb_tb

# a failing run is judged by the missing pass line below
out=$(./obj_dir/Vbtb_tb) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF 'All tests passed!'; then
    exit 0
fi
exit 1
